//--- dmni_dma.f
+incdir+common
common/dmni_pkg.sv
common/dma_mem_if.sv
src/dma_arbiter.sv
dma_receive/dma_receive.sv
dma_send/dma_send.sv
src/dma_mem_mux.sv
src/dmni_dma.sv
sim/tb_dmni_dma.sv

//--- build.sh
#!/usr/bin/env bash
# Build the DMNI DMA testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dmni_dma -f dmni_dma.f \
    -o tb_dmni_dma \
    && ./obj_dir/tb_dmni_dma | tee /dev/stderr | grep -q "^TEST OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/tb_dmni_dma.sv
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the DMNI DMA with seeded random traffic
// Holds the memory, both network ends and a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module tb_dmni_dma;
    import dmni_pkg::*;

    localparam int    MEM_WORDS = 1024;
    localparam addr_t BUF_A     = 32'h0000_0400;
    localparam addr_t BUF_B     = 32'h0000_0600;
    localparam addr_t BUF_C     = 32'h0000_0700;
    localparam addr_t BUF_D     = 32'h0000_0800;
    localparam addr_t SEG_1     = 32'h0000_0C00;
    localparam addr_t SEG_2     = 32'h0000_0D00;
    localparam addr_t SEG_3     = 32'h0000_0E00;
    localparam addr_t SEG_4     = 32'h0000_0F00;

    logic        clk_i;
    logic        rst_ni;
    logic        noc_rx_i;
    logic        noc_eop_i;
    flit_t       noc_data_i;
    logic        noc_credit_o;
    logic        noc_tx_o;
    logic        noc_eop_o;
    logic        noc_ack_i;
    flit_t       noc_data_o;
    logic        mem_en_o;
    be_t         mem_we_o;
    addr_t       mem_addr_o;
    flit_t       mem_data_i;
    flit_t       mem_data_o;
    logic        st_rcv_i;
    logic        st_snd_i;
    size_t       size_i;
    size_t       size_2_i;
    addr_t       address_i;
    addr_t       address_2_i;
    logic [31:0] received_cnt_o;
    logic        send_active_o;
    logic        receive_active_o;
    logic        receive_available_o;

    flit_t       mem_array [MEM_WORDS];
    flit_t       ref_mem [MEM_WORDS];
    flit_t       rx_flits [$];
    logic        rx_eops [$];
    flit_t       tx_exp [$];
    logic        rx_taken    = 1'b0;
    logic        rx_ended    = 1'b0;
    logic        rx_full     = 1'b0;
    logic        send_ended  = 1'b0;
    addr_t       model_addr  = '0;
    size_t       model_size  = '0;
    logic [31:0] model_cnt   = '0;
    logic [31:0] rng_state   = 32'd90235;
    int          value_errs  = 0;
    int          other_errs  = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 100000;

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    dmni_dma DUT (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .noc_rx_i            (noc_rx_i),
        .noc_eop_i           (noc_eop_i),
        .noc_data_i          (noc_data_i),
        .noc_credit_o        (noc_credit_o),
        .noc_tx_o            (noc_tx_o),
        .noc_eop_o           (noc_eop_o),
        .noc_ack_i           (noc_ack_i),
        .noc_data_o          (noc_data_o),
        .mem_en_o            (mem_en_o),
        .mem_we_o            (mem_we_o),
        .mem_addr_o          (mem_addr_o),
        .mem_data_i          (mem_data_i),
        .mem_data_o          (mem_data_o),
        .st_rcv_i            (st_rcv_i),
        .st_snd_i            (st_snd_i),
        .size_i              (size_i),
        .size_2_i            (size_2_i),
        .address_i           (address_i),
        .address_2_i         (address_2_i),
        .received_cnt_o      (received_cnt_o),
        .send_active_o       (send_active_o),
        .receive_active_o    (receive_active_o),
        .receive_available_o (receive_available_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory model with combinational read
    //////////////////////////////////////////////////////////////////////

    assign mem_data_i = mem_array[mem_addr_o[11:2]];

    always @(posedge clk_i) begin
        if (mem_en_o && mem_we_o == '1) begin
            mem_array[mem_addr_o[11:2]] <= mem_data_o;
        end
    end

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic flit_t fill_word(input int idx);
        return 32'hD000_0000 ^ (32'(idx) * 32'h0001_0003);
    endfunction

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Network ends driven on the falling edge
    //////////////////////////////////////////////////////////////////////

    initial begin
        noc_rx_i   = 1'b0;
        noc_eop_i  = 1'b0;
        noc_data_i = '0;
        noc_ack_i  = 1'b0;
        forever begin
            @(negedge clk_i);
            // An offered flit stays until credit
            if (!noc_rx_i || rx_taken) begin
                rx_taken = 1'b0;
                if (rx_flits.size() > 0 && next_rand() % 4 != 0) begin
                    noc_rx_i   = 1'b1;
                    noc_data_i = rx_flits[0];
                    noc_eop_i  = rx_eops[0];
                end else begin
                    noc_rx_i  = 1'b0;
                    noc_eop_i = 1'b0;
                end
            end
            noc_ack_i = (next_rand() % 3 != 0);
        end
    end

    // Reference model step for one consumed flit
    task automatic receive_flit();
        if (model_size == '0) begin
            other_errs++;
            $display("A flit was consumed after the receive buffer was full");
        end else if (model_addr != '0) begin
            check_bit("mem_we_o", mem_en_o && mem_we_o == '1, 1'b1);
            check_addr("mem_addr_o", mem_addr_o, model_addr);
            check_flit("mem_data_o", mem_data_o, rx_flits[0]);
            ref_mem[model_addr[11:2]] = rx_flits[0];
            model_addr = model_addr + addr_t'(`DMNI_WORD_BYTES);
        end else if (mem_en_o) begin
            other_errs++;
            $display("Memory was written for a flit sent to the discard buffer");
        end
        model_size = model_size - 1;
        model_cnt  = model_cnt + `DMNI_WORD_BYTES;
        // Packet end wins over a full buffer
        if (rx_eops[0]) begin
            rx_ended = 1'b1;
        end else if (model_size == '0) begin
            rx_full = 1'b1;
        end
        void'(rx_flits.pop_front());
        void'(rx_eops.pop_front());
        rx_taken = 1'b1;
    endtask

    task automatic send_flit();
        if (tx_exp.size() == 0) begin
            other_errs++;
            $display("The send engine delivered a flit that was never scheduled");
        end else begin
            check_flit("noc_data_o", noc_data_o, tx_exp[0]);
            check_bit("noc_eop_o", noc_eop_o, tx_exp.size() == 1);
            send_ended = (tx_exp.size() == 1);
            void'(tx_exp.pop_front());
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni) begin
            check_count("received_cnt_o", received_cnt_o, model_cnt);
            if (send_ended) begin
                check_bit("send_active_o", send_active_o, 1'b0);
            end
            if (rx_ended) begin
                check_bit("receive_active_o", receive_active_o, 1'b0);
            end
            if (rx_full) begin
                check_bit("receive_available_o", receive_available_o, 1'b1);
            end
            send_ended = 1'b0;
            rx_ended   = 1'b0;
            rx_full    = 1'b0;
            if (mem_en_o && noc_tx_o && noc_credit_o) begin
                other_errs++;
                $display("Memory port used while send and receive both handshook");
            end
            if (st_rcv_i) begin
                model_addr = address_i;
                model_size = size_i;
                model_cnt  = '0;
            end
            if (noc_rx_i && noc_credit_o) begin
                receive_flit();
            end
            if (noc_tx_o && noc_ack_i) begin
                send_flit();
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Run stopped after %0d cycles, the transfers never finished", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequence helpers called on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic push_packet(input int len);
        for (int i = 0; i < len; i++) begin
            rx_flits.push_back(next_rand());
            rx_eops.push_back(i == len - 1);
        end
    endtask

    task automatic wait_available();
        while (!receive_available_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic program_receive(input addr_t addr, input size_t words);
        address_i = addr;
        size_i    = words;
        st_rcv_i  = 1'b1;
        @(negedge clk_i);
        st_rcv_i  = 1'b0;
    endtask

    task automatic wait_receive_done();
        while (rx_flits.size() != 0 || receive_active_o) begin
            @(negedge clk_i);
        end
    endtask

    // Expected flits come from the model memory
    task automatic start_send(input addr_t a1, input int n1, input addr_t a2, input int n2);
        for (int i = 0; i < n1; i++) begin
            tx_exp.push_back(ref_mem[int'(a1 >> 2) + i]);
        end
        for (int i = 0; i < n2; i++) begin
            tx_exp.push_back(ref_mem[int'(a2 >> 2) + i]);
        end
        address_i   = a1;
        size_i      = size_t'(n1);
        address_2_i = a2;
        size_2_i    = size_t'(n2);
        st_snd_i    = 1'b1;
        @(negedge clk_i);
        st_snd_i    = 1'b0;
    endtask

    task automatic wait_send_done();
        while (tx_exp.size() != 0 || send_active_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic check_reset_levels();
        check_bit("noc_credit_o", noc_credit_o, 1'b0);
        check_bit("noc_tx_o", noc_tx_o, 1'b0);
        check_bit("noc_eop_o", noc_eop_o, 1'b0);
        check_bit("mem_en_o", mem_en_o, 1'b0);
        check_bit("mem_we_o", |mem_we_o, 1'b0);
        check_bit("send_active_o", send_active_o, 1'b0);
        check_bit("receive_active_o", receive_active_o, 1'b0);
        check_bit("receive_available_o", receive_available_o, 1'b0);
        check_count("received_cnt_o", received_cnt_o, '0);
    endtask

    initial begin
        int len_a;
        int len_b;
        int split;
        int len_c;
        int len_d;
        int s1;
        int s2;
        int s3;
        int s4;

        rst_ni      = 1'b0;
        st_rcv_i    = 1'b0;
        st_snd_i    = 1'b0;
        size_i      = '0;
        size_2_i    = '0;
        address_i   = '0;
        address_2_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_array[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end

        len_a = 2 + int'(next_rand() % 11);
        len_b = 2 + int'(next_rand() % 11);
        split = 1 + int'(next_rand() % (len_b - 1));
        len_c = 2 + int'(next_rand() % 11);
        len_d = 2 + int'(next_rand() % 11);
        s1    = 1 + int'(next_rand() % 6);
        s2    = 1 + int'(next_rand() % 6);
        s3    = 1 + int'(next_rand() % 6);
        s4    = 1 + int'(next_rand() % 6);
        cycle_limit = (len_a + len_b + len_c + len_d + s1 + s2 + s3 + s4) * 40 + 200;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_reset_levels();

        // One buffer, packet ends on eop
        push_packet(len_a);
        wait_available();
        program_receive(BUF_A, size_t'(len_a + 3));
        wait_receive_done();

        // Packet split over two buffers
        push_packet(len_b);
        wait_available();
        program_receive(BUF_B, size_t'(split));
        wait_available();
        program_receive(BUF_C, size_t'(len_b - split));
        wait_receive_done();
        check_count("received_cnt_o", received_cnt_o, 32'(4 * (len_b - split)));

        // Discard buffer at address zero
        push_packet(len_c);
        wait_available();
        program_receive('0, size_t'(len_c));
        wait_receive_done();
        check_count("received_cnt_o", received_cnt_o, 32'(4 * len_c));

        // Two segments under ack back-pressure
        start_send(SEG_1, s1, SEG_2, s2);
        wait_send_done();

        // Send and receive at the same time
        push_packet(len_d);
        wait_available();
        program_receive(BUF_D, size_t'(len_d));
        start_send(SEG_3, s3, SEG_4, s4);
        wait_send_done();
        wait_receive_done();

        for (int i = 0; i < MEM_WORDS; i++) begin
            check_flit($sformatf("mem[%0d]", i), mem_array[i], ref_mem[i]);
        end

        $display("Run complete, %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/dmni_dma.sv
//////////////////////////////////////////////////////////////////////
// DMNI DMA top level, network port, memory port and software levels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmni_dma (
    input  logic            clk_i,
    input  logic            rst_ni,

    // Network receive side
    input  logic            noc_rx_i,
    input  logic            noc_eop_i,
    input  dmni_pkg::flit_t noc_data_i,
    output logic            noc_credit_o,

    // Network send side
    output logic            noc_tx_o,
    output logic            noc_eop_o,
    input  logic            noc_ack_i,
    output dmni_pkg::flit_t noc_data_o,

    // Shared memory port
    output logic            mem_en_o,
    output dmni_pkg::be_t   mem_we_o,
    output dmni_pkg::addr_t mem_addr_o,
    input  dmni_pkg::flit_t mem_data_i,
    output dmni_pkg::flit_t mem_data_o,

    // Software configuration and status
    input  logic            st_rcv_i,
    input  logic            st_snd_i,
    input  dmni_pkg::size_t size_i,
    input  dmni_pkg::size_t size_2_i,
    input  dmni_pkg::addr_t address_i,
    input  dmni_pkg::addr_t address_2_i,
    output logic [31:0]     received_cnt_o,
    output logic            send_active_o,
    output logic            receive_active_o,
    output logic            receive_available_o
);
    import dmni_pkg::*;

    grant_t grant;

    dma_mem_if recv_mem ();
    dma_mem_if send_mem ();

    dma_arbiter u_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .send_active_i (send_active_o),
        .recv_active_i (receive_active_o),
        .grant_o       (grant)
    );

    dma_receive u_receive (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .grant_i        (grant),
        .rx_i           (noc_rx_i),
        .eop_i          (noc_eop_i),
        .data_i         (noc_data_i),
        .credit_o       (noc_credit_o),
        .st_rcv_i       (st_rcv_i),
        .size_i         (size_i),
        .address_i      (address_i),
        .received_cnt_o (received_cnt_o),
        .active_o       (receive_active_o),
        .available_o    (receive_available_o),
        .mem            (recv_mem.engine)
    );

    dma_send u_send (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .grant_i     (grant),
        .ack_i       (noc_ack_i),
        .tx_o        (noc_tx_o),
        .eop_o       (noc_eop_o),
        .data_o      (noc_data_o),
        .st_snd_i    (st_snd_i),
        .size_i      (size_i),
        .size_2_i    (size_2_i),
        .address_i   (address_i),
        .address_2_i (address_2_i),
        .active_o    (send_active_o),
        .mem         (send_mem.engine)
    );

    dma_mem_mux u_mem_mux (
        .grant_i    (grant),
        .send_mem   (send_mem.port),
        .recv_mem   (recv_mem.port),
        .mem_en_o   (mem_en_o),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o),
        .mem_data_i (mem_data_i)
    );

endmodule

`default_nettype wire

//--- src/dma_mem_mux.sv
//////////////////////////////////////////////////////////////////////
// Puts the granted engine on the single memory port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dma_mem_mux (
    input  dmni_pkg::grant_t grant_i,
    dma_mem_if.port          send_mem,
    dma_mem_if.port          recv_mem,
    output logic             mem_en_o,
    output dmni_pkg::be_t    mem_we_o,
    output dmni_pkg::addr_t  mem_addr_o,
    output dmni_pkg::flit_t  mem_data_o,
    input  dmni_pkg::flit_t  mem_data_i
);
    import dmni_pkg::*;

    always_comb begin
        mem_en_o   = 1'b0;
        mem_we_o   = '0;
        mem_addr_o = '0;
        mem_data_o = '0;
        case (grant_i)
            GRANT_SEND: begin
                mem_en_o   = send_mem.en;
                mem_we_o   = send_mem.we;
                mem_addr_o = send_mem.addr;
                mem_data_o = send_mem.wdata;
            end
            GRANT_RECEIVE: begin
                mem_en_o   = recv_mem.en;
                mem_we_o   = recv_mem.we;
                mem_addr_o = recv_mem.addr;
                mem_data_o = recv_mem.wdata;
            end
            default: ;
        endcase
    end

    // Both engines see the read data, only the owner uses it
    assign send_mem.rdata = mem_data_i;
    assign recv_mem.rdata = mem_data_i;

endmodule

`default_nettype wire

//--- dma_send/dma_send.sv
//////////////////////////////////////////////////////////////////////
// Send engine, streams one or two memory segments onto the network
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module dma_send (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  dmni_pkg::grant_t grant_i,
    input  logic             ack_i,
    output logic             tx_o,
    output logic             eop_o,
    output dmni_pkg::flit_t  data_o,
    input  logic             st_snd_i,
    input  dmni_pkg::size_t  size_i,
    input  dmni_pkg::size_t  size_2_i,
    input  dmni_pkg::addr_t  address_i,
    input  dmni_pkg::addr_t  address_2_i,
    output logic             active_o,
    dma_mem_if.engine        mem
);
    import dmni_pkg::*;

    typedef enum logic [1:0] {
        SND_IDLE,
        SND_DATA,
        SND_STOP
    } snd_state_t;

    snd_state_t state_q;
    snd_state_t state_d;
    addr_t      addr_q;
    addr_t      addr_2_q;
    size_t      size_q;
    size_t      size_2_q;
    addr_t      addr_d;
    addr_t      addr_2_d;
    size_t      size_d;
    size_t      size_2_d;
    logic       take;
    logic       last_d;

    // Flit leaves only with tx and ack in the same cycle
    assign tx_o = (state_q != SND_IDLE) && (grant_i == GRANT_SEND);
    assign take = tx_o && ack_i;

    //////////////////////////////////////////////////////////////////////
    // Segment pointers
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_d   = addr_q;
        addr_2_d = addr_2_q;
        size_d   = size_q;
        size_2_d = size_2_q;
        if (state_q == SND_IDLE) begin
            addr_d   = address_i;
            addr_2_d = address_2_i;
            size_d   = size_i;
            size_2_d = size_2_i;
        end else if (take) begin
            // First segment drains before the second
            if (size_q != '0) begin
                addr_d = addr_q + addr_t'(`DMNI_WORD_BYTES);
                size_d = size_q - 1'b1;
            end else begin
                addr_2_d = addr_2_q + addr_t'(`DMNI_WORD_BYTES);
                size_2_d = size_2_q - 1'b1;
            end
        end
    end

    // Exactly one word left after this cycle
    assign last_d = (size_d == size_t'(1) && size_2_d == '0)
                 || (size_d == '0 && size_2_d == size_t'(1));

    always_ff @(posedge clk_i) begin
        addr_q   <= addr_d;
        addr_2_q <= addr_2_d;
        size_q   <= size_d;
        size_2_q <= size_2_d;
    end

    //////////////////////////////////////////////////////////////////////
    // State machine, STOP presents the final word
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            SND_IDLE: begin
                if (st_snd_i) begin
                    state_d = last_d ? SND_STOP : SND_DATA;
                end
            end
            SND_DATA: begin
                if (take && last_d) begin
                    state_d = SND_STOP;
                end
            end
            SND_STOP: begin
                if (take) begin
                    state_d = SND_IDLE;
                end
            end
            default: state_d = SND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SND_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign active_o = (state_q != SND_IDLE);
    assign eop_o    = tx_o && (state_q == SND_STOP);
    // Read data is valid in the same cycle as the address
    assign data_o   = mem.rdata;

    assign mem.en    = tx_o;
    assign mem.we    = '0;
    assign mem.addr  = (size_q != '0) ? addr_q : addr_2_q;
    assign mem.wdata = '0;

endmodule

`default_nettype wire

//--- dma_receive/dma_receive.sv
//////////////////////////////////////////////////////////////////////
// Receive engine, copies network flits into memory
// Software programs a buffer after each available indication
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module dma_receive (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  dmni_pkg::grant_t grant_i,
    input  logic             rx_i,
    input  logic             eop_i,
    input  dmni_pkg::flit_t  data_i,
    output logic             credit_o,
    input  logic             st_rcv_i,
    input  dmni_pkg::size_t  size_i,
    input  dmni_pkg::addr_t  address_i,
    output logic [31:0]      received_cnt_o,
    output logic             active_o,
    output logic             available_o,
    dma_mem_if.engine        mem
);
    import dmni_pkg::*;

    typedef enum logic [1:0] {
        RCV_HEADER,
        RCV_WAIT,
        RCV_DATA
    } rcv_state_t;

    rcv_state_t state_q;
    rcv_state_t state_d;
    addr_t      addr_q;
    size_t      size_q;
    logic       consume;
    logic       store;

    assign active_o    = (state_q == RCV_DATA);
    assign available_o = (state_q == RCV_WAIT);

    // One flit per granted cycle with data present
    assign consume = active_o && rx_i && (grant_i == GRANT_RECEIVE);
    // Buffer at address zero drops the flits
    assign store   = consume && (addr_q != '0);

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            RCV_HEADER: begin
                // Header is only observed here, it is consumed as data
                if (rx_i) begin
                    state_d = RCV_WAIT;
                end
            end
            RCV_WAIT: begin
                if (st_rcv_i) begin
                    state_d = RCV_DATA;
                end
            end
            RCV_DATA: begin
                if (consume) begin
                    if (eop_i) begin
                        state_d = RCV_HEADER;
                    end else if (size_q == size_t'(1)) begin
                        state_d = RCV_WAIT;
                    end
                end
            end
            default: state_d = RCV_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RCV_HEADER;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Buffer pointer and byte count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (state_q == RCV_WAIT) begin
            addr_q <= address_i;
            size_q <= size_i;
        end else if (consume) begin
            if (addr_q != '0) begin
                addr_q <= addr_q + addr_t'(`DMNI_WORD_BYTES);
            end
            size_q <= size_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            received_cnt_o <= '0;
        end else if (st_rcv_i) begin
            received_cnt_o <= '0;
        end else if (consume) begin
            received_cnt_o <= received_cnt_o + 32'(`DMNI_WORD_BYTES);
        end
    end

    assign credit_o  = consume;
    assign mem.en    = store;
    assign mem.we    = store ? '1 : '0;
    assign mem.addr  = addr_q;
    assign mem.wdata = data_i;

endmodule

`default_nettype wire

//--- src/dma_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Round-robin owner of the memory port, send versus receive
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module dma_arbiter (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             send_active_i,
    input  logic             recv_active_i,
    output dmni_pkg::grant_t grant_o
);
    import dmni_pkg::*;

    grant_t                     grant_d;
    logic [`DMNI_QUANTUM_W-1:0] timer_q;
    logic                       owner_active;
    logic                       other_active;

    always_comb begin
        case (grant_o)
            GRANT_SEND: begin
                owner_active = send_active_i;
                other_active = recv_active_i;
            end
            GRANT_RECEIVE: begin
                owner_active = recv_active_i;
                other_active = send_active_i;
            end
            default: begin
                owner_active = 1'b0;
                other_active = send_active_i || recv_active_i;
            end
        endcase
    end

    // Hand over on idle owner or expired quantum
    always_comb begin
        grant_d = grant_o;
        if (!send_active_i && !recv_active_i) begin
            grant_d = GRANT_NONE;
        end else if (!owner_active || (timer_q == '0 && other_active)) begin
            case (grant_o)
                GRANT_SEND:    grant_d = recv_active_i ? GRANT_RECEIVE : GRANT_SEND;
                GRANT_RECEIVE: grant_d = send_active_i ? GRANT_SEND : GRANT_RECEIVE;
                default:       grant_d = recv_active_i ? GRANT_RECEIVE : GRANT_SEND;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            grant_o <= GRANT_NONE;
            timer_q <= '1;
        end else begin
            grant_o <= grant_d;
            // Fresh quantum for every new owner
            if (!owner_active || grant_d != grant_o) begin
                timer_q <= '1;
            end else begin
                timer_q <= timer_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/dma_mem_if.sv
//////////////////////////////////////////////////////////////////////
// Memory request and read data of one DMA engine
// The engine side drives the request, the mux side returns read data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface dma_mem_if;
    import dmni_pkg::*;

    logic  en;
    be_t   we;
    addr_t addr;
    flit_t wdata;
    flit_t rdata;

    modport engine (
        output en, we, addr, wdata,
        input  rdata
    );

    modport port (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- common/dmni_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the DMNI DMA engine, its blocks and the testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dmni_defs.svh"

package dmni_pkg;

    // One flit or one memory word
    typedef logic [`DMNI_FLIT_W-1:0] flit_t;

    // Byte address and word count
    typedef logic [`DMNI_ADDR_W-1:0] addr_t;
    typedef logic [`DMNI_ADDR_W-1:0] size_t;

    // Byte write enables, one per byte of a word
    typedef logic [`DMNI_FLIT_W/8-1:0] be_t;

    // Current owner of the memory port and network handshakes
    typedef enum logic [1:0] {
        GRANT_NONE    = 2'd0,
        GRANT_SEND    = 2'd1,
        GRANT_RECEIVE = 2'd2
    } grant_t;

endpackage

`default_nettype wire

//--- common/dmni_defs.svh
//////////////////////////////////////////////////////////////////////
// Width and timing constants for the DMNI DMA engine
// Include before the package and in any block that needs the values
//////////////////////////////////////////////////////////////////////

`ifndef DMNI_DEFS_SVH
`define DMNI_DEFS_SVH

// Flit and memory word width
`define DMNI_FLIT_W 32

// Byte address and word count width
`define DMNI_ADDR_W 32

// Address step between consecutive words
`define DMNI_WORD_BYTES 4

// Arbiter timer width, quantum of 2**W cycles
`define DMNI_QUANTUM_W 4

`endif
